/* hw/fpFormatPkg.sv */
package fpFormatPkg;

	// ==================================================
	// IEEE 754 field layout derived from a word width
	// ==================================================

	// width of the biased exponent field
	// half, single, double and quad layouts are known
	// any other width falls back to the single layout
	function automatic int expBits(input int width);
		int bits;
		case (width)
			16: bits = 5;
			64: bits = 11;
			128: bits = 15;
			default: bits = 8;
		endcase
		return bits;
	endfunction

	// stored fraction bits, the hidden bit is not counted
	// sign takes one bit, the exponent takes the rest above the fraction
	function automatic int fracBits(input int width);
		int bits;
		bits = width - 1 - expBits(width);
		return bits;
	endfunction

	// exponent bias, half the exponent range minus one
	// 127 for single, 1023 for double
	function automatic int expBias(input int width);
		int bias;
		bias = (1 << (expBits(width) - 1)) - 1;
		return bias;
	endfunction

endpackage

/* hw/fpOpPkg.sv */
package fpOpPkg;

	// ==================================================
	// operation select and status flags
	// ==================================================

	// operation code presented with each start strobe
	// code 2'b11 has no name and runs as a truncate
	typedef enum logic [1:0] {
		// keep the float format, clear the fraction below the point
		opTrunc = 2'b00,
		// float to signed integer, toward zero, saturating
		opToInt = 2'b01,
		// signed integer to float, low bits dropped
		opToFp = 2'b10
	} fpOp;

	// status that travels with every result
	typedef struct packed {
		// result did not fit and was clamped
		logic overflow;
		// operand was a NaN
		logic invalid;
	} fpFlags;

endpackage

/* hw/fpResultIf.sv */
`timescale 1ns/1ps

// registered output of one conversion unit
// no handshake, contents change only on the unit's ce
interface fpResultIf #(
	parameter int WID = 32
);

	// converted word
	logic [WID-1:0] value;
	// overflow and invalid for that word
	fpOpPkg::fpFlags flags;

	// the conversion unit owns the register
	modport unit (
		output value,
		output flags
	);

	// the selection stage only samples it
	modport sel (
		input value,
		input flags
	);

endinterface

/* hw/fpTrunc.sv */
`timescale 1ns/1ps

// float truncate, drops the fraction below the binary point
// result keeps the float format, one register stage on ce
module fpTrunc #(
	parameter int WID = 32
) (
	input logic clk,
	input logic ce,
	input logic [WID-1:0] a,
	fpResultIf.unit res
);

	localparam int expW = fpFormatPkg::expBits(WID);
	localparam int fracW = fpFormatPkg::fracBits(WID);
	localparam int bias = fpFormatPkg::expBias(WID);
	// biased exponent of 1.0
	localparam logic [expW-1:0] biasExp = expW'(bias);
	// from here on every stored fraction bit sits above the point
	localparam logic [expW-1:0] passExp = expW'(bias + fracW);

	logic sign;
	logic [expW-1:0] expField;
	logic [fracW-1:0] fracField;
	logic [expW-1:0] intBits;
	logic [fracW-1:0] keepMask;
	logic [WID-1:0] chopped;

	// ==================================================
	// field split and fraction mask
	// ==================================================

	assign sign = a[WID-1];
	assign expField = a[WID-2 -: expW];
	assign fracField = a[fracW-1:0];

	// count of fraction bits that are integer bits
	// only meaningful when the value is at least one
	assign intBits = expField - biasExp;

	// keep the top intBits of the fraction, clear the rest
	assign keepMask = ~({fracW{1'b1}} >> intBits);

	always_comb begin
		if (expField < biasExp)
			// magnitude below one, denormals included
			chopped = '0;
		else if (expField >= passExp)
			// already integral, also inf and NaN
			chopped = a;
		else
			chopped = {sign, expField, fracField & keepMask};
	end

	// output register, holds while ce is low
	always_ff @(posedge clk) begin
		if (ce) begin
			res.value <= chopped;
			res.flags <= '0;
		end
	end

endmodule

/* hw/fpToInt.sv */
`timescale 1ns/1ps

// float to signed integer, rounds toward zero
// out of range saturates and flags overflow, NaN gives zero and invalid
module fpToInt #(
	parameter int WID = 32
) (
	input logic clk,
	input logic ce,
	input logic [WID-1:0] a,
	fpResultIf.unit res
);

	localparam int expW = fpFormatPkg::expBits(WID);
	localparam int fracW = fpFormatPkg::fracBits(WID);
	localparam int bias = fpFormatPkg::expBias(WID);
	localparam logic [expW-1:0] biasExp = expW'(bias);
	// exponent of 2^(WID-1), first magnitude that no longer fits
	localparam logic [expW-1:0] ovfExp = expW'(bias + WID - 1);
	localparam logic [WID-1:0] maxInt = {1'b0, {(WID-1){1'b1}}};
	localparam logic [WID-1:0] minInt = {1'b1, {(WID-1){1'b0}}};

	logic sign;
	logic [expW-1:0] expField;
	logic [fracW-1:0] fracField;
	logic isNaN;
	logic [expW-1:0] shiftAmt;
	logic [WID+fracW-1:0] shifted;
	logic [WID-1:0] mag;
	logic [WID-1:0] nextValue;
	logic nextOvf;
	logic nextInv;

	assign sign = a[WID-1];
	assign expField = a[WID-2 -: expW];
	assign fracField = a[fracW-1:0];
	assign isNaN = (expField == '1) && (fracField != '0);

	// ==================================================
	// magnitude path
	// ==================================================

	// unbiased exponent, below WID-1 whenever the shift result is used
	assign shiftAmt = expField - biasExp;

	// mantissa with hidden bit, the binary point sits above bit fracW-1
	assign shifted = {{(WID-1){1'b0}}, 1'b1, fracField} << shiftAmt;

	// integer part only, bits under the point are dropped
	assign mag = shifted[WID+fracW-1 -: WID];

	always_comb begin
		nextValue = '0;
		nextOvf = 1'b0;
		nextInv = 1'b0;
		if (isNaN) begin
			nextInv = 1'b1;
		end else if (expField >= ovfExp) begin
			// too large, infinity lands here as well
			nextValue = sign ? minInt : maxInt;
			// -2^(WID-1) is representable and is not an overflow
			nextOvf = !(sign && (expField == ovfExp) && (fracField == '0));
		end else if (expField >= biasExp) begin
			nextValue = sign ? -mag : mag;
		end
		// magnitude below one keeps the zero default
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			res.value <= nextValue;
			res.flags.overflow <= nextOvf;
			res.flags.invalid <= nextInv;
		end
	end

	// a flagged invalid result never carries a partial value
	invalidGivesZero: assert property (
		@(posedge clk) ce |=> (!res.flags.invalid || (res.value == '0))
	) else $error("fpToInt: invalid result with nonzero value %h", res.value);

endmodule

/* hw/intToFp.sv */
`timescale 1ns/1ps

// signed integer to float
// bits that do not fit the fraction are dropped, so it rounds toward zero
module intToFp #(
	parameter int WID = 32
) (
	input logic clk,
	input logic ce,
	input logic [WID-1:0] a,
	fpResultIf.unit res
);

	localparam int expW = fpFormatPkg::expBits(WID);
	localparam int fracW = fpFormatPkg::fracBits(WID);
	localparam int bias = fpFormatPkg::expBias(WID);
	localparam logic [expW-1:0] biasExp = expW'(bias);
	// width of a bit position inside the word
	localparam int posW = $clog2(WID);

	logic sign;
	logic [WID-1:0] mag;
	logic [posW-1:0] lead;
	logic [posW-1:0] normShift;
	logic [WID-1:0] norm;
	logic [expW-1:0] expField;
	logic [fracW-1:0] fracField;
	logic [WID-1:0] fltWord;

	// ==================================================
	// magnitude and leading one
	// ==================================================

	assign sign = a[WID-1];
	// the most negative input comes out as 2^(WID-1), still correct unsigned
	assign mag = sign ? -a : a;

	// priority search, the highest set bit wins
	always_comb begin
		lead = '0;
		for (int i = 0; i < WID; i++) begin
			if (mag[i])
				lead = posW'(i);
		end
	end

	// ==================================================
	// normalize and pack
	// ==================================================

	// move the leading one up to the top bit
	assign normShift = posW'(WID - 1) - lead;
	assign norm = mag << normShift;

	// hidden bit is implied, take what follows it
	// low bits past the fraction width fall off here
	assign fracField = norm[WID-2 -: fracW];
	assign expField = biasExp + expW'(lead);

	// zero has no leading one and maps to +0
	assign fltWord = (mag == '0) ? '0 : {sign, expField, fracField};

	always_ff @(posedge clk) begin
		if (ce) begin
			res.value <= fltWord;
			res.flags <= '0;
		end
	end

	// no integer reaches the inf/NaN exponent
	expNeverMax: assert property (
		@(posedge clk) ce |=> (res.value[WID-2 -: expW] != '1)
	) else $error("intToFp: exponent all ones in %h", res.value);

endmodule

/* hw/fpConvSelect.sv */
`timescale 1ns/1ps

// output stage of the conversion pipe
// op and start wait one cycle for the units, then the chosen result is registered
module fpConvSelect #(
	parameter int WID = 32
) (
	input logic clk,
	input logic reset,
	input logic start,
	input fpOpPkg::fpOp op,
	fpResultIf.sel truncRes,
	fpResultIf.sel intRes,
	fpResultIf.sel fltRes,
	output logic done,
	output logic [WID-1:0] result,
	output fpOpPkg::fpFlags flags
);

	// strobe and op code one cycle behind, lined up with the unit registers
	logic startQ;
	fpOpPkg::fpOp opQ;

	// ==================================================
	// delay and result mux
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			startQ <= 1'b0;
			opQ <= fpOpPkg::opTrunc;
			done <= 1'b0;
			result <= '0;
			flags <= '0;
		end else begin
			startQ <= start;
			// op only matters on a strobe
			if (start)
				opQ <= op;
			// one pulse per strobe, back to back strobes give back to back pulses
			done <= startQ;
			if (startQ) begin
				case (opQ)
					fpOpPkg::opToInt: begin
						result <= intRes.value;
						flags <= intRes.flags;
					end
					fpOpPkg::opToFp: begin
						result <= fltRes.value;
						flags <= fltRes.flags;
					end
					// unused code 2'b11 runs as truncate
					default: begin
						result <= truncRes.value;
						flags <= truncRes.flags;
					end
				endcase
			end
		end
	end

	// every done pulse goes back to a strobe exactly two cycles earlier
	doneFollowsStart: assert property (
		@(posedge clk) disable iff (reset) done |-> $past(start, 2)
	) else $error("fpConvSelect: done without a start two cycles before");

	// only float-to-int can raise a flag
	flagsOnlyToInt: assert property (
		@(posedge clk) disable iff (reset)
		(done && ($past(opQ) != fpOpPkg::opToInt)) |-> (flags == '0)
	) else $error("fpConvSelect: flags %b on a non float-to-int result", flags);

endmodule

/* hw/fpConvUnit.sv */
`timescale 1ns/1ps

// floating point conversion unit
// truncate, float to int, int to float, result two cycles after start
module fpConvUnit #(
	parameter int WID = 32
) (
	input logic clk,
	input logic reset,
	input logic start,
	input fpOpPkg::fpOp op,
	input logic [WID-1:0] a,
	output logic done,
	output logic [WID-1:0] result,
	output logic overflow,
	output logic invalid
);

	// registered flags from the selection stage
	fpOpPkg::fpFlags flags;

	// one result bus per conversion unit
	fpResultIf #(.WID(WID)) truncRes ();
	fpResultIf #(.WID(WID)) intRes ();
	fpResultIf #(.WID(WID)) fltRes ();

	// ==================================================
	// conversion units, all load on start
	// ==================================================

	fpTrunc #(.WID(WID)) u_trunc (
		.clk(clk),
		.ce(start),
		.a(a),
		.res(truncRes.unit)
	);

	fpToInt #(.WID(WID)) u_toInt (
		.clk(clk),
		.ce(start),
		.a(a),
		.res(intRes.unit)
	);

	intToFp #(.WID(WID)) u_toFp (
		.clk(clk),
		.ce(start),
		.a(a),
		.res(fltRes.unit)
	);

	// second stage picks the unit named by op
	fpConvSelect #(.WID(WID)) u_select (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.truncRes(truncRes.sel),
		.intRes(intRes.sel),
		.fltRes(fltRes.sel),
		.done(done),
		.result(result),
		.flags(flags)
	);

	// flags leave the design as plain bits
	assign overflow = flags.overflow;
	assign invalid = flags.invalid;

endmodule

/* testbench/tbClock.sv */
`timescale 1ns/1ps

// free running clock and a synchronous reset held for the first cycles
module tbClock #(
	parameter int halfPeriod = 5,
	parameter int resetCycles = 4
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// release lands just after an edge, like the other inputs
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

/* testbench/fpConvTb.sv */
`timescale 1ns/1ps

module fpConvTb;

	localparam int WID = 32;
	localparam int maxVec = 64;
	// words per vector: op, operand, result, overflow, invalid
	localparam int vecWords = 5;
	localparam int doneTimeout = 20;
	localparam int resetTimeout = 50;

	logic clk;
	logic reset;
	logic start;
	fpOpPkg::fpOp op;
	logic [WID-1:0] a;
	logic done;
	logic [WID-1:0] result;
	logic overflow;
	logic invalid;

	logic [WID-1:0] vecMem [0:maxVec*vecWords-1];
	int numVec = 0;
	int errors = 0;
	int cycle = 0;

	// expected entries in strobe order
	logic [WID-1:0] expResult [$];
	logic expOvf [$];
	logic expInv [$];
	int expCycle [$];
	int expIndex [$];

	tbClock #(.halfPeriod(5), .resetCycles(4)) u_clock (.clk(clk), .reset(reset));

	fpConvUnit #(.WID(WID)) i_dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.a(a),
		.done(done),
		.result(result),
		.overflow(overflow),
		.invalid(invalid)
	);

	// cycle count, used for the latency check
	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic compareValue(input string name, input logic [WID-1:0] got,
		input logic [WID-1:0] expected, input int index);
		if (got !== expected) begin
			errors++;
			$display("[FAIL] %s: got %h expected %h (vector %0d)", name, got, expected, index);
		end
	endtask

	// outputs after reset with nothing in flight
	task automatic checkIdle();
		compareValue("done", WID'(done), '0, -1);
		compareValue("result", result, '0, -1);
		compareValue("overflow", WID'(overflow), '0, -1);
		compareValue("invalid", WID'(invalid), '0, -1);
	endtask

	// ==================================================
	// stimulus
	// ==================================================

	task automatic driveVectors();
		for (int i = 0; i < numVec; i++) begin
			@(posedge clk);
			#1;
			start = 1'b1;
			op = fpOpPkg::fpOp'(vecMem[i*vecWords][1:0]);
			a = vecMem[i*vecWords+1];
			expResult.push_back(vecMem[i*vecWords+2]);
			expOvf.push_back(vecMem[i*vecWords+3][0]);
			expInv.push_back(vecMem[i*vecWords+4][0]);
			expCycle.push_back(cycle);
			expIndex.push_back(i);
			// idle cycle after every sixth strobe
			if (i % 6 == 5) begin
				@(posedge clk);
				#1;
				start = 1'b0;
			end
		end
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	// ==================================================
	// result checking, one done pulse per strobe
	// ==================================================

	task automatic checkResults();
		int waited;
		int index;
		for (int n = 0; n < numVec; n++) begin
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!done && waited < doneTimeout);
			if (!done) begin
				errors++;
				$display("timeout: no done pulse for operation %0d in %0d cycles",
					n, doneTimeout);
				return;
			end
			if (expResult.size() == 0) begin
				errors++;
				$display("done pulse with no operation pending at cycle %0d", cycle);
			end else begin
				index = expIndex.pop_front();
				if (cycle - expCycle[0] != 2) begin
					errors++;
					$display("vector %0d: done came %0d cycles after its strobe instead of 2",
						index, cycle - expCycle[0]);
				end
				void'(expCycle.pop_front());
				compareValue("result", result, expResult.pop_front(), index);
				compareValue("overflow", WID'(overflow), WID'(expOvf.pop_front()), index);
				compareValue("invalid", WID'(invalid), WID'(expInv.pop_front()), index);
			end
		end
	endtask

	initial begin
		int waited;
		start = 1'b0;
		op = fpOpPkg::opTrunc;
		a = '0;
		$readmemh("testbench/fpConvTests.txt", vecMem);
		while (numVec < maxVec && !$isunknown(vecMem[numVec*vecWords]))
			numVec++;
		if (numVec == 0) begin
			errors++;
			$display("no test vectors were read from the test file");
		end
		// wait for reset release
		waited = 0;
		while (reset && waited < resetTimeout) begin
			@(negedge clk);
			waited++;
		end
		if (reset) begin
			errors++;
			$display("timeout: reset was never released");
		end
		// quiet outputs after reset with no strobe
		repeat (3) begin
			@(negedge clk);
			checkIdle();
		end
		fork
			driveVectors();
			checkResults();
		join
		// no extra pulse once the pipe has drained
		repeat (3) begin
			@(negedge clk);
			compareValue("done", WID'(done), '0, -1);
		end
		$display("%0d vectors, %0d errors", numVec, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* testbench/fpConvTests.txt */
// op (0 trunc, 1 toInt, 2 toFp, 3 as trunc), operand, expected result,
// expected overflow, expected invalid; all hex
0 40700000 40400000 0 0
0 C0200000 C0000000 0 0
0 3F000000 00000000 0 0
0 BF400000 00000000 0 0
0 3F800000 3F800000 0 0
0 42F6E979 42F60000 0 0
0 4E800000 4E800000 0 0
0 501502F9 501502F9 0 0
0 7F800000 7F800000 0 0
0 7FC00000 7FC00000 0 0
1 40FCCCCD 00000007 0 0
1 C0FCCCCD FFFFFFF9 0 0
1 4F000000 7FFFFFFF 1 0
1 7F800000 7FFFFFFF 1 0
1 FF800000 80000000 1 0
1 CF000000 80000000 0 0
1 7FC00000 00000000 0 1
1 3F000000 00000000 0 0
1 4E800000 40000000 0 0
1 CF32D05E 80000000 1 0
2 00000000 00000000 0 0
2 00000001 3F800000 0 0
2 FFFFFFFF BF800000 0 0
2 7FFFFFFF 4EFFFFFF 0 0
2 80000000 CF000000 0 0
2 01000001 4B800000 0 0
// mixed operations back to back
1 7FC00000 00000000 0 1
2 00000064 42C80000 0 0
0 C0200000 C0000000 0 0
1 501502F9 7FFFFFFF 1 0
2 FFFFFF9C C2C80000 0 0
3 40700000 40400000 0 0
1 42F6E979 0000007B 0 0

/* compile.f */
hw/fpFormatPkg.sv
hw/fpOpPkg.sv
hw/fpResultIf.sv
hw/fpTrunc.sv
hw/fpToInt.sv
hw/intToFp.sv
hw/fpConvSelect.sv
hw/fpConvUnit.sv
testbench/tbClock.sv
testbench/fpConvTb.sv
